// ==== hw/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // ****************************************
  // instruction encodings
  // ****************************************

  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_LUI    = 7'b0110111,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  // ****************************************
  // control
  // ****************************************

  typedef enum logic [3:0] {
    S_IDLE,
    S_FETCH,
    S_DECODE,
    S_MEM_ADR,
    S_MEM_READ,
    S_MEM_WB,
    S_MEM_WRITE,
    S_EXEC_R,
    S_EXEC_I,
    S_ALU_WB,
    S_JAL,
    S_BRANCH,
    S_LUI,
    S_HALT
  } state_t;

  typedef enum logic {ADR_PC, ADR_RESULT} adr_src_t;
  typedef enum logic [1:0] {A_PC, A_OLD_PC, A_RD1, A_ZERO} alu_src_a_t;
  typedef enum logic [1:0] {B_RD2, B_IMM, B_FOUR} alu_src_b_t;
  typedef enum logic [1:0] {RES_ALU_OUT, RES_DATA, RES_ALU_RESULT} result_src_t;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu import rv_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result,
  output logic    zero
);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: begin
        if ($signed(a) < $signed(b)) begin
          result = word_t'(1);
        end else begin
          result = '0;
        end
      end
      default: result = a + b;
    endcase
  end

  assign zero = (result == '0); // branches compare via SUB

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t ra1,
  input  reg_idx_t ra2,
  input  reg_idx_t wa,
  input  logic     we,
  input  word_t    wd,
  output word_t    rd1,
  output word_t    rd2
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin // x0 never written
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  // write-back data comes from the core's result mux
  a_wd_known: assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(wd));

endmodule

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  pc_write,
  input  logic  ir_write,
  input  word_t next_pc,
  output word_t pc,
  output word_t pc_old
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= RESET_PC;
      pc_old <= RESET_PC;
    end else begin
      if (ir_write) begin
        pc_old <= pc; // address of the instruction being latched
      end
      if (pc_write) begin
        pc <= next_pc;
      end
    end
  end

endmodule

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode import rv_pkg::*; (
  input  word_t      instr,
  output opcode_t    opcode,
  output logic [2:0] funct3,
  output reg_idx_t   rd,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output word_t      imm,
  output alu_op_t    alu_op
);

  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  always_comb begin
    case (instr[6:0])
      OP_R, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL, OP_LUI: opcode = opcode_t'(instr[6:0]);
      default: opcode = OP_SYSTEM; // anything unknown halts
    endcase
  end

  always_comb begin
    case (opcode)
      OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      OP_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      OP_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      OP_LUI:    imm = {instr[31:12], 12'b0};
      default:   imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  always_comb begin
    alu_op = ALU_ADD; // addresses, LUI
    if (opcode == OP_BRANCH) begin
      alu_op = ALU_SUB;
    end else if (opcode == OP_R || opcode == OP_IMM) begin
      case (funct3)
        3'b000: alu_op = (opcode == OP_R && instr[30]) ? ALU_SUB : ALU_ADD;
        3'b010: alu_op = ALU_SLT;
        3'b100: alu_op = ALU_XOR;
        3'b110: alu_op = ALU_OR;
        3'b111: alu_op = ALU_AND;
        default: alu_op = ALU_ADD;
      endcase
    end
  end

endmodule

// ==== hw/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  opcode_t     opcode,
  input  logic [2:0]  funct3,
  input  logic        zero,
  output adr_src_t    adr_src,
  output logic        ir_write,
  output logic        pc_write,
  output logic        reg_write,
  output logic        mem_we,
  output alu_src_a_t  alu_src_a,
  output alu_src_b_t  alu_src_b,
  output result_src_t result_src,
  output logic        core_active,
  output logic        halted
);

  state_t state, state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ****************************************
  // next state
  // ****************************************

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:     if (start) state_next = S_FETCH;
      S_FETCH:    state_next = S_DECODE;
      S_DECODE: begin
        case (opcode)
          OP_LOAD, OP_STORE: state_next = S_MEM_ADR;
          OP_R:              state_next = S_EXEC_R;
          OP_IMM:            state_next = S_EXEC_I;
          OP_JAL:            state_next = S_JAL;
          OP_BRANCH:         state_next = S_BRANCH;
          OP_LUI:            state_next = S_LUI;
          default:           state_next = S_HALT; // ECALL
        endcase
      end
      S_MEM_ADR:  state_next = (opcode == OP_LOAD) ? S_MEM_READ : S_MEM_WRITE;
      S_MEM_READ: state_next = S_MEM_WB;
      S_EXEC_R, S_EXEC_I, S_JAL: state_next = S_ALU_WB;
      S_MEM_WB, S_MEM_WRITE, S_ALU_WB, S_BRANCH, S_LUI: state_next = S_FETCH;
      S_HALT:     state_next = S_HALT; // only rst leaves
      default:    state_next = S_IDLE;
    endcase
  end

  // ****************************************
  // outputs
  // ****************************************

  always_comb begin
    adr_src    = ADR_PC;
    alu_src_a  = A_PC;
    alu_src_b  = B_FOUR;
    result_src = RES_ALU_OUT;
    ir_write   = 1'b0;
    pc_write   = 1'b0;
    reg_write  = 1'b0;
    mem_we     = 1'b0;
    case (state)
      S_FETCH: begin
        result_src = RES_ALU_RESULT; // pc + 4
        pc_write   = 1'b1;
        ir_write   = 1'b1;
      end
      S_DECODE: begin // jump/branch target into alu_out
        alu_src_a = A_OLD_PC;
        alu_src_b = B_IMM;
      end
      S_MEM_ADR: begin
        alu_src_a = A_RD1;
        alu_src_b = B_IMM;
      end
      S_MEM_READ:  adr_src = ADR_RESULT;
      S_MEM_WB: begin
        result_src = RES_DATA;
        reg_write  = 1'b1;
      end
      S_MEM_WRITE: begin
        adr_src = ADR_RESULT;
        mem_we  = 1'b1;
      end
      S_EXEC_R: begin
        alu_src_a = A_RD1;
        alu_src_b = B_RD2;
      end
      S_EXEC_I: begin
        alu_src_a = A_RD1;
        alu_src_b = B_IMM;
      end
      S_ALU_WB:    reg_write = 1'b1;
      S_JAL: begin // pc <- target, alu_out <- link
        alu_src_a = A_OLD_PC;
        pc_write  = 1'b1;
      end
      S_BRANCH: begin
        alu_src_a = A_RD1;
        alu_src_b = B_RD2;
        pc_write  = funct3[0] ? !zero : zero; // bne : beq
      end
      S_LUI: begin
        alu_src_a  = A_ZERO;
        alu_src_b  = B_IMM;
        result_src = RES_ALU_RESULT;
        reg_write  = 1'b1;
      end
      default: ;
    endcase
  end

  assign core_active = (state != S_IDLE) && (state != S_HALT);
  assign halted      = (state == S_HALT);

  a_we_store: assert property (@(posedge clk) disable iff (rst)
    mem_we |-> (state == S_MEM_WRITE) && (opcode == OP_STORE));
  a_ir_fetch: assert property (@(posedge clk) disable iff (rst)
    (state != S_FETCH) && core_active |=> $stable(opcode));

endmodule

// ==== hw/multicycle_core.sv ====
`timescale 1ns/1ps

module multicycle_core import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  output word_t mem_addr,
  output word_t mem_wdata,
  output logic  mem_we,
  input  word_t mem_rdata,
  output logic  core_active,
  output logic  halted
);

  adr_src_t    adr_src;
  alu_src_a_t  alu_src_a;
  alu_src_b_t  alu_src_b;
  result_src_t result_src;
  logic        ir_write, pc_write, reg_write, zero;

  word_t      pc, pc_old, instr, data, alu_out, data_a, data_b;
  word_t      rd1, rd2, imm, src_a, src_b, alu_result, result;
  opcode_t    opcode;
  logic [2:0] funct3;
  reg_idx_t   rd, rs1, rs2;
  alu_op_t    dec_alu_op, alu_op;

  control_fsm control_fsm_i (
    .clk, .rst, .start, .opcode, .funct3, .zero, .adr_src, .ir_write, .pc_write,
    .reg_write, .mem_we, .alu_src_a, .alu_src_b, .result_src, .core_active, .halted
  );

  pc_unit #(.RESET_PC(RESET_PC)) pc_unit_i (
    .clk, .rst, .pc_write, .ir_write, .next_pc(result), .pc, .pc_old
  );

  instr_decode instr_decode_i (
    .instr, .opcode, .funct3, .rd, .rs1, .rs2, .imm, .alu_op(dec_alu_op)
  );

  reg_file reg_file_i (
    .clk, .rst, .ra1(rs1), .ra2(rs2), .wa(rd), .we(reg_write), .wd(result), .rd1, .rd2
  );

  // pc arithmetic always adds, register operands follow the decoder
  assign alu_op = (alu_src_a == A_RD1) ? dec_alu_op : ALU_ADD;

  alu alu_i (.a(src_a), .b(src_b), .op(alu_op), .result(alu_result), .zero);

  always_ff @(posedge clk) begin
    if (rst) begin
      instr <= '0;
    end else if (ir_write) begin
      instr <= mem_rdata;
    end
  end

  always_ff @(posedge clk) begin // operand, data and alu-out latches
    data    <= mem_rdata;
    alu_out <= alu_result;
    data_a  <= rd1;
    data_b  <= rd2;
  end

  always_comb begin
    case (alu_src_a)
      A_PC:     src_a = pc;
      A_OLD_PC: src_a = pc_old;
      A_RD1:    src_a = data_a;
      default:  src_a = '0;
    endcase
    case (alu_src_b)
      B_RD2:   src_b = data_b;
      B_IMM:   src_b = imm;
      default: src_b = word_t'(4);
    endcase
    case (result_src)
      RES_DATA:       result = data;
      RES_ALU_RESULT: result = alu_result;
      default:        result = alu_out;
    endcase
  end

  assign mem_addr  = (adr_src == ADR_RESULT) ? result : pc;
  assign mem_wdata = data_b;

endmodule

// ==== hw/unified_memory.sv ====
`timescale 1ns/1ps

module unified_memory import rv_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic  clk,
  input  logic  core_active,
  input  word_t mem_addr,
  input  word_t mem_wdata,
  input  logic  mem_we,
  output word_t mem_rdata,
  input  word_t boot_addr,
  input  word_t boot_wdata,
  input  logic  boot_we,
  output word_t boot_rdata
);

  localparam int AW = $clog2(MEM_WORDS);

  word_t mem [MEM_WORDS];

  logic [AW-1:0] core_idx, boot_idx;

  assign core_idx = mem_addr[AW+1:2];
  assign boot_idx = boot_addr[AW+1:2];

  // core owns the array while running, boot port otherwise
  always_ff @(posedge clk) begin
    if (core_active && mem_we) begin
      mem[core_idx] <= mem_wdata;
    end else if (!core_active && boot_we) begin
      mem[boot_idx] <= boot_wdata;
    end
  end

  assign mem_rdata  = core_active ? mem[core_idx] : '0;
  assign boot_rdata = core_active ? '0 : mem[boot_idx];

  a_core_in_range: assert property (@(posedge clk) core_active |-> (mem_addr[31:2] < MEM_WORDS));

endmodule

// ==== hw/rv_system.sv ====
`timescale 1ns/1ps

module rv_system import rv_pkg::*; #(
  parameter int    MEM_WORDS = 256,
  parameter word_t RESET_PC  = '0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  boot_we,
  input  word_t boot_addr,
  input  word_t boot_wdata,
  output word_t boot_rdata,
  output logic  halted
);

  word_t mem_addr, mem_wdata, mem_rdata;
  logic  mem_we, core_active;

  multicycle_core #(.RESET_PC(RESET_PC)) core_i (
    .clk, .rst, .start, .mem_addr, .mem_wdata, .mem_we, .mem_rdata, .core_active, .halted
  );

  unified_memory #(.MEM_WORDS(MEM_WORDS)) memory_i (
    .clk, .core_active, .mem_addr, .mem_wdata, .mem_we, .mem_rdata,
    .boot_addr, .boot_wdata, .boot_we, .boot_rdata
  );

endmodule

// ==== tests/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int PROG_BASE  = 32'h0000_0000;
localparam int ARITH_BASE = 32'h0000_0200;
localparam int MEM_BASE   = 32'h0000_0240;
localparam int LOOP_BASE  = 32'h0000_0280;
localparam int JUMP_BASE  = 32'h0000_02c0;

localparam word_t ECALL_WORD = 32'h0000_0073;

localparam logic [2:0] F3_ADD = 3'b000;
localparam logic [2:0] F3_SLT = 3'b010;
localparam logic [2:0] F3_XOR = 3'b100;
localparam logic [2:0] F3_OR  = 3'b110;
localparam logic [2:0] F3_AND = 3'b111;
localparam logic [2:0] F3_BEQ = 3'b000;
localparam logic [2:0] F3_BNE = 3'b001;
localparam logic [6:0] F7_STD = 7'h00;
localparam logic [6:0] F7_SUB = 7'h20;

localparam int LOOP_COUNT = 5;

word_t prog_words [64];
int    prog_len;
word_t exp_addr [16];
word_t exp_data [16];
int    exp_len;

// ****************************************
// RV32I encoders
// ****************************************

function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
  return {f7, reg_idx_t'(rs2), reg_idx_t'(rs1), f3, reg_idx_t'(rd), 7'b0110011};
endfunction

function automatic word_t enc_addi(int rd, int rs1, int imm);
  return {imm[11:0], reg_idx_t'(rs1), 3'b000, reg_idx_t'(rd), 7'b0010011};
endfunction

function automatic word_t enc_lw(int rd, int rs1, int imm);
  return {imm[11:0], reg_idx_t'(rs1), 3'b010, reg_idx_t'(rd), 7'b0000011};
endfunction

function automatic word_t enc_sw(int rs2, int rs1, int imm);
  return {imm[11:5], reg_idx_t'(rs2), reg_idx_t'(rs1), 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic word_t enc_branch(logic [2:0] f3, int rs1, int rs2, int off);
  return {off[12], off[10:5], reg_idx_t'(rs2), reg_idx_t'(rs1), f3, off[4:1], off[11],
          7'b1100011};
endfunction

function automatic word_t enc_jal(int rd, int off);
  return {off[20], off[10:1], off[11], off[19:12], reg_idx_t'(rd), 7'b1101111};
endfunction

function automatic word_t enc_lui(int rd, logic [19:0] upper);
  return {upper, reg_idx_t'(rd), 7'b0110111};
endfunction

task automatic begin_program();
  prog_len = 0;
  exp_len  = 0;
endtask

task automatic emit(word_t w);
  prog_words[prog_len] = w;
  prog_len++;
endtask

task automatic expect_result(word_t addr, word_t value);
  exp_addr[exp_len] = addr;
  exp_data[exp_len] = value;
  exp_len++;
endtask

// ****************************************
// directed programs
// ****************************************

task automatic build_arith_program();
  int a;
  int b;
  a = -1234;
  b = 567;
  begin_program();
  emit(enc_addi(1, 0, a));
  emit(enc_addi(2, 0, b));
  emit(enc_r(F7_STD, F3_ADD, 3, 1, 2));
  emit(enc_r(F7_SUB, F3_ADD, 4, 1, 2));
  emit(enc_r(F7_STD, F3_AND, 5, 1, 2));
  emit(enc_r(F7_STD, F3_OR, 6, 1, 2));
  emit(enc_r(F7_STD, F3_XOR, 7, 1, 2));
  emit(enc_r(F7_STD, F3_SLT, 8, 1, 2));
  emit(enc_r(F7_STD, F3_SLT, 9, 2, 1));
  emit(enc_addi(10, 1, -77));
  for (int r = 3; r <= 10; r++) begin
    emit(enc_sw(r, 0, ARITH_BASE + 4 * (r - 3)));
  end
  emit(ECALL_WORD);
  expect_result(ARITH_BASE + 0, a + b);
  expect_result(ARITH_BASE + 4, a - b);
  expect_result(ARITH_BASE + 8, a & b);
  expect_result(ARITH_BASE + 12, a | b);
  expect_result(ARITH_BASE + 16, a ^ b);
  expect_result(ARITH_BASE + 20, (a < b) ? 1 : 0); // signed compare
  expect_result(ARITH_BASE + 24, (b < a) ? 1 : 0);
  expect_result(ARITH_BASE + 28, a - 77);
endtask

task automatic build_mem_program();
  logic [19:0] hi;
  int          lo;
  word_t       value;
  hi    = 20'hcafe5;
  lo    = -477;
  value = {hi, 12'h000} + word_t'(lo); // lui then addi
  begin_program();
  emit(enc_addi(5, 0, 32'h200));
  emit(enc_lui(1, hi));
  emit(enc_addi(1, 1, lo));
  emit(enc_sw(1, 5, MEM_BASE - 32'h200));
  emit(enc_lw(2, 5, MEM_BASE - 32'h200));
  emit(enc_addi(2, 2, 1));
  emit(enc_sw(2, 5, MEM_BASE + 4 - 32'h200));
  emit(ECALL_WORD);
  expect_result(MEM_BASE, value);
  expect_result(MEM_BASE + 4, value + 1);
endtask

task automatic build_loop_program();
  begin_program();
  emit(enc_addi(1, 0, LOOP_COUNT));
  emit(enc_addi(2, 0, 0));
  emit(enc_addi(3, 0, 7));
  emit(enc_addi(2, 2, 1));              // loop body
  emit(enc_addi(1, 1, -1));
  emit(enc_branch(F3_BNE, 1, 0, -8));
  emit(enc_branch(F3_BEQ, 2, 2, 8));    // always taken
  emit(enc_addi(3, 0, 99));             // skipped
  emit(enc_branch(F3_BEQ, 1, 2, 8));    // never taken
  emit(enc_addi(4, 0, 42));
  emit(enc_sw(2, 0, LOOP_BASE));
  emit(enc_sw(3, 0, LOOP_BASE + 4));
  emit(enc_sw(4, 0, LOOP_BASE + 8));
  emit(ECALL_WORD);
  expect_result(LOOP_BASE, LOOP_COUNT);
  expect_result(LOOP_BASE + 4, 7);
  expect_result(LOOP_BASE + 8, 42);
endtask

task automatic build_jump_program();
  word_t       jal_addr;
  logic [19:0] upper;
  upper = 20'habcde;
  begin_program();
  emit(enc_addi(5, 0, 1));
  jal_addr = PROG_BASE + 4 * prog_len;
  emit(enc_jal(1, 8));
  emit(enc_addi(5, 0, 2)); // jumped over
  emit(enc_lui(2, upper));
  emit(enc_addi(0, 0, 123));
  emit(enc_sw(1, 0, JUMP_BASE));
  emit(enc_sw(2, 0, JUMP_BASE + 4));
  emit(enc_sw(0, 0, JUMP_BASE + 8));
  emit(enc_sw(5, 0, JUMP_BASE + 12));
  emit(ECALL_WORD);
  expect_result(JUMP_BASE, jal_addr + 4);
  expect_result(JUMP_BASE + 4, {upper, 12'h000});
  expect_result(JUMP_BASE + 8, 0);
  expect_result(JUMP_BASE + 12, 1);
endtask

`endif

// ==== tests/tb_rv_system.sv ====
`timescale 1ns/1ps

module tb_rv_system import rv_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int DRIVE_DELAY  = 1;
  localparam int MEM_WORDS    = 256;
  localparam int NUM_PROGRAMS = 4;
  localparam int RUN_LIMIT    = 1000;
  localparam int BOOT_WORDS   = 16;
  localparam int BOOT_BASE    = 32'h300;

  logic  clk, rst, start, boot_we, halted;
  word_t boot_addr, boot_wdata, boot_rdata;

  int errors;
  int checks;
  int seed;

  `include "tb_programs.svh"

  rv_system #(.MEM_WORDS(MEM_WORDS), .RESET_PC(word_t'(PROG_BASE))) rv_system_i (
    .clk, .rst, .start, .boot_we, .boot_addr, .boot_wdata, .boot_rdata, .halted
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_PROGRAMS * 2000 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish", NUM_PROGRAMS * 2000);
    $display("=== FAIL ===");
    $finish;
  end

  // ****************************************
  // bus tasks
  // ****************************************

  task automatic apply_reset();
    @(posedge clk);
    #DRIVE_DELAY;
    rst     = 1'b1;
    start   = 1'b0;
    boot_we = 1'b0;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
  endtask

  task automatic write_boot(word_t addr, word_t data);
    @(posedge clk);
    #DRIVE_DELAY;
    boot_we    = 1'b1;
    boot_addr  = addr;
    boot_wdata = data;
    @(posedge clk); // word lands here
    #DRIVE_DELAY;
    boot_we = 1'b0;
  endtask

  task automatic read_boot(word_t addr, output word_t data);
    @(posedge clk);
    #DRIVE_DELAY;
    boot_addr = addr;
    #DRIVE_DELAY;
    data = boot_rdata;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #DRIVE_DELAY;
    start = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    start = 1'b0;
  endtask

  task automatic check_word(word_t addr, word_t expected);
    word_t got;
    read_boot(addr, got);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("** Error: boot_rdata at 0x%08h = 0x%08h, expected 0x%08h", addr, got, expected);
    end
  endtask

  task automatic check_bit(string name, logic got, logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  function automatic word_t fill_word(word_t addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  // result words get a fill first so a missing store shows up
  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      write_boot(PROG_BASE + 4 * i, prog_words[i]);
    end
    for (int i = 0; i < exp_len; i++) begin
      write_boot(exp_addr[i], fill_word(exp_addr[i]));
    end
  endtask

  task automatic run_program();
    int cycles;
    cycles = 0;
    pulse_start();
    while (!halted && cycles < RUN_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("core did not halt within %0d cycles", RUN_LIMIT);
    end
  endtask

  task automatic check_results();
    for (int i = 0; i < exp_len; i++) begin
      check_word(exp_addr[i], exp_data[i]);
    end
  endtask

  task automatic execute_program();
    apply_reset();
    load_program();
    run_program();
    check_results();
  endtask

  // ****************************************
  // directed tests
  // ****************************************

  task automatic test_boot_port();
    word_t data [BOOT_WORDS];
    apply_reset();
    check_bit("halted", halted, 1'b0);
    for (int i = 0; i < BOOT_WORDS; i++) begin
      data[i] = $urandom();
      write_boot(BOOT_BASE + 4 * i, data[i]);
    end
    repeat (10) @(posedge clk); // idle core must not write
    #DRIVE_DELAY;
    check_bit("halted", halted, 1'b0);
    for (int i = 0; i < BOOT_WORDS; i++) begin
      check_word(BOOT_BASE + 4 * i, data[i]);
    end
  endtask

  task automatic test_arith();
    build_arith_program();
    execute_program();
  endtask

  task automatic test_mem_round_trip();
    build_mem_program();
    execute_program();
  endtask

  task automatic test_branch_loop();
    build_loop_program();
    execute_program();
  endtask

  task automatic test_jump_lui();
    build_jump_program();
    execute_program();
  endtask

  // runs right after a halted program, memory still holds it
  task automatic test_halt_hold();
    repeat (20) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_bit("halted", halted, 1'b1);
    end
    pulse_start();
    repeat (20) @(posedge clk);
    #DRIVE_DELAY;
    check_bit("halted", halted, 1'b1);
    check_results();
    for (int i = 0; i < prog_len; i++) begin
      check_word(PROG_BASE + 4 * i, prog_words[i]);
    end
  endtask

  initial begin
    rst        = 1'b1;
    start      = 1'b0;
    boot_we    = 1'b0;
    boot_addr  = '0;
    boot_wdata = '0;
    errors     = 0;
    checks     = 0;
    seed       = 11309;
    void'($urandom(seed));
    test_boot_port();
    test_arith();
    test_mem_round_trip();
    test_branch_loop();
    test_jump_lui();
    test_halt_hold();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+tests
hw/rv_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/pc_unit.sv
hw/instr_decode.sv
hw/control_fsm.sv
hw/multicycle_core.sv
hw/unified_memory.sv
hw/rv_system.sv
tests/tb_rv_system.sv

// ==== Bender.yml ====
package:
  name: rv_multicycle

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/alu.sv
      - hw/reg_file.sv
      - hw/pc_unit.sv
      - hw/instr_decode.sv
      - hw/control_fsm.sv
      - hw/multicycle_core.sv
      - hw/unified_memory.sv
      - hw/rv_system.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_system.sv
